//--- host_bridge_top.sv
// top level wiring command and response queues, controller, bus port and RAM
module host_bridge_top
	import host_cmd_pkg::*;
	import wb_bus_pkg::*;
#(
	parameter int FIFO_DEPTH  = 4,
	parameter int RAM_ADDR_W  = 8,
	parameter int WAIT_STATES = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic cmd_valid_i,
	input  cmd_t cmd_i,
	output logic cmd_ready_o,
	output logic rsp_valid_o,
	output rsp_t rsp_o,
	input  logic rsp_ready_i
);
	logic cmd_full;
	logic cmd_empty;
	logic cmd_pop;
	cmd_t cmd_head;
	logic rsp_full;
	logic rsp_empty;
	logic rsp_push;
	rsp_t rsp_next;
	logic req_valid;
	wb_req_t req;
	logic busy;
	logic done;
	wb_rsp_t port_rsp;
	logic [WB_ADDR_W-1:0] wb_adr;
	logic [WB_DATA_W-1:0] wb_dat_w;
	logic [WB_DATA_W-1:0] wb_dat_r;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;

	assign cmd_ready_o = !cmd_full;
	assign rsp_valid_o = !rsp_empty;

	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(cmd_t)) u_cmd_fifo (
		.clk(clk), .rst(rst),
		.push_i(cmd_valid_i), .data_i(cmd_i), .full_o(cmd_full),
		.pop_i(cmd_pop), .data_o(cmd_head), .empty_o(cmd_empty)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(rsp_t)) u_rsp_fifo (
		.clk(clk), .rst(rst),
		.push_i(rsp_push), .data_i(rsp_next), .full_o(rsp_full),
		.pop_i(rsp_ready_i), .data_o(rsp_o), .empty_o(rsp_empty)
	);

	wb_master_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.cmd_empty_i(cmd_empty), .cmd_i(cmd_head), .cmd_pop_o(cmd_pop),
		.rsp_full_i(rsp_full), .rsp_push_o(rsp_push), .rsp_o(rsp_next),
		.req_valid_o(req_valid), .req_o(req), .busy_i(busy),
		.done_i(done), .wb_rsp_i(port_rsp)
	);

	wb_port u_port (
		.clk(clk), .rst(rst),
		.req_valid_i(req_valid), .req_i(req), .busy_o(busy),
		.done_o(done), .rsp_o(port_rsp),
		.wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r),
		.wb_we_o(wb_we), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_ack_i(wb_ack)
	);

	wb_ram #(.RAM_ADDR_W(RAM_ADDR_W), .WAIT_STATES(WAIT_STATES)) u_ram (
		.clk(clk), .rst(rst),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
		.wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_ack_o(wb_ack)
	);

endmodule

//--- host_cmd_pkg.sv
// host command opcodes, ping signature, command beat and response record types
package host_cmd_pkg;

	// opcodes as carried in the code field of a command beat
	typedef enum logic [31:0] {
		PING      = 32'd0,
		WRITE     = 32'd1,
		READ      = 32'd2,
		WSTREAM_C = 32'd3,
		RSTREAM_C = 32'd5,
		RSTREAM   = 32'd6
	} cmd_code_e;

	// data word returned for a ping
	localparam logic [31:0] PING_SIGNATURE = 32'h00001EAF;

	// one command beat from the host
	// code is kept as a raw word so unknown opcodes can still arrive
	// stream commands carry the word count in data,
	// write stream data beats use data only
	typedef struct packed {
		logic [31:0] code;
		logic [31:0] addr;
		logic [31:0] data;
	} cmd_t;

	// one response record to the host
	// status is the inverted opcode
	typedef struct packed {
		logic [31:0] status;
		logic [31:0] addr;
		logic [31:0] data;
		logic [15:0] count;
	} rsp_t;

endpackage

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_host_bridge -f src.f \
	&& ./obj_dir/Vtb_host_bridge > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no pass status found in log"; exit 1; }
echo "simulation passed"

//--- src.f
host_cmd_pkg.sv
wb_bus_pkg.sv
sync_fifo.sv
wb_master_ctrl.sv
wb_port.sv
wb_ram.sv
host_bridge_top.sv
tb_rsp_checker.sv
tb_host_bridge_asserts.sv
tb_host_bridge.sv

//--- sync_fifo.sv
// synchronous circular-buffer FIFO with first-word-fall-through output and typed payload
module sync_fifo #(
	parameter int  DEPTH     = 4,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push_i,
	input  payload_t data_i,
	output logic     full_o,
	input  logic     pop_i,
	output payload_t data_o,
	output logic     empty_o
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full_o  = (count == CNT_W'(DEPTH));
	assign empty_o = (count == '0);
	// requests against a full or empty queue are dropped here
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	// head entry is visible without a pop
	assign data_o  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

endmodule

//--- tb_host_bridge.sv
// testbench top with clock, reset, random command stimulus and the RAM model
module tb_host_bridge
	import host_cmd_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 5000;

	logic clk;
	logic rst;
	logic cmd_valid_i;
	cmd_t cmd_i;
	logic cmd_ready_o;
	logic rsp_valid_o;
	rsp_t rsp_o;
	logic rsp_ready_i;

	// reference copy of the 256-word RAM
	logic [31:0] model_mem [256];
	int seed;
	int ready_pct;
	int fail_cnt;
	int exp_total;
	int test_num;
	int err_base;

	host_bridge_top #(.FIFO_DEPTH(4), .RAM_ADDR_W(8), .WAIT_STATES(2)) i_host_bridge_top (
		.clk(clk), .rst(rst),
		.cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i), .cmd_ready_o(cmd_ready_o),
		.rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o), .rsp_ready_i(rsp_ready_i)
	);

	tb_rsp_checker u_rsp_checker (
		.clk(clk), .rst(rst), .cmd_ready_i(cmd_ready_o), .rsp_valid_i(rsp_valid_o),
		.rsp_ready_i(rsp_ready_i), .rsp_i(rsp_o)
	);

	always #4 clk = ~clk;

	// host takes responses at a random rate
	// draw on the edge, apply 1 ns later
	always @(posedge clk) begin
		logic take;
		take = (({$random(seed)} % 100) < ready_pct);
		#1;
		rsp_ready_i = take;
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic int count_errors();
		return u_rsp_checker.err_cnt + fail_cnt + i_host_bridge_top.u_asserts.err_cnt;
	endfunction

	function automatic rsp_t make_rsp(input logic [31:0] code, input logic [31:0] addr,
		input logic [31:0] data, input logic [15:0] count);
		rsp_t r;
		r.status = ~code;
		r.addr   = addr;
		r.data   = data;
		r.count  = count;
		return r;
	endfunction

	function automatic void push_expect(input rsp_t r);
		u_rsp_checker.expect_rsp(r);
		exp_total++;
	endfunction

	task automatic send_beat(input logic [31:0] code, input logic [31:0] addr,
		input logic [31:0] data);
		int waited;
		waited = 0;
		cmd_valid_i = 1'b1;
		cmd_i = '{code: code, addr: addr, data: data};
		while (!cmd_ready_o && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!cmd_ready_o) begin
			$display("timeout: command queue stayed full for %0d cycles", TIMEOUT_CYCLES);
			fail_cnt++;
		end
		@(posedge clk);
		#1;
		cmd_valid_i = 1'b0;
	endtask

	task automatic do_ping();
		push_expect(make_rsp(PING, 32'd0, PING_SIGNATURE, 16'd0));
		send_beat(PING, 32'd0, 32'd0);
	endtask

	task automatic do_write(input logic [31:0] addr, input logic [31:0] data);
		model_mem[addr[7:0]] = data;
		push_expect(make_rsp(WRITE, addr, data, 16'd0));
		send_beat(WRITE, addr, data);
	endtask

	task automatic do_read(input logic [31:0] addr);
		push_expect(make_rsp(READ, addr, model_mem[addr[7:0]], 16'd0));
		send_beat(READ, addr, 32'd0);
	endtask

	task automatic do_rstream(input logic [31:0] code, input logic [31:0] addr,
		input logic [15:0] n);
		logic [31:0] a;
		a = addr;
		// header record first
		push_expect(make_rsp(code, addr, 32'd0, n));
		for (int i = 0; i < int'(n); i++) begin
			push_expect(make_rsp(code, a, model_mem[a[7:0]], n - 16'(i)));
			if (code == RSTREAM_C)
				a = a + 32'd1;
		end
		send_beat(code, addr, {16'd0, n});
	endtask

	task automatic do_wstream(input logic [31:0] addr, input logic [15:0] n);
		logic [31:0] words [$];
		logic [31:0] a;
		for (int i = 0; i < int'(n); i++) begin
			a = addr + 32'(i);
			words.push_back(rand_word());
			model_mem[a[7:0]] = words[i];
		end
		push_expect(make_rsp(WSTREAM_C, addr, words[words.size() - 1], n));
		send_beat(WSTREAM_C, addr, {16'd0, n});
		// data beats, only the data field counts
		foreach (words[i])
			send_beat(32'd0, 32'd0, words[i]);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (u_rsp_checker.pending() != 0 && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (u_rsp_checker.pending() != 0) begin
			$display("timeout: %0d responses still missing after %0d cycles",
				u_rsp_checker.pending(), TIMEOUT_CYCLES);
			fail_cnt++;
		end
		// quiet window, a stray response would show up here
		repeat (20) @(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name);
		int errs;
		wait_drain();
		errs = count_errors() - err_base;
		if (errs == 0)
			$display("test %0d %s: ok", test_num, name);
		else
			$display("test %0d %s: %0d errors", test_num, name, errs);
		err_base += errs;
		test_num++;
	endtask

	initial begin
		logic [31:0] addrs [$];
		logic [31:0] a;
		logic [15:0] n;
		int pick;
		seed = 32'h81d1;
		clk = 1'b0;
		rst = 1'b1;
		cmd_valid_i = 1'b0;
		cmd_i = '0;
		rsp_ready_i = 1'b1;
		ready_pct = 100;
		fail_cnt = 0;
		exp_total = 0;
		test_num = 1;
		err_base = 0;
		foreach (model_mem[i])
			model_mem[i] = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		ready_pct = 75;

		do_ping();
		end_test("ping");

		for (int i = 0; i < 12; i++) begin
			a = rand_word() & 32'h3ff;
			addrs.push_back(a);
			do_write(a, rand_word());
		end
		// 0x1ff and 0x0ff hit the same RAM word
		do_write(32'h1ff, rand_word());
		addrs.push_back(32'h0ff);
		foreach (addrs[i])
			do_read(addrs[i]);
		end_test("single write and read");

		// at least two words so the read back order matters
		a = rand_word() & 32'hff;
		n = 16'(2 + rand_word() % 31);
		do_wstream(a, n);
		do_rstream(RSTREAM_C, a, n);
		end_test("write stream and read back");

		// at least two words so a moving address would show
		a = rand_word() & 32'h3ff;
		do_write(a, rand_word());
		do_rstream(RSTREAM, a, 16'(2 + rand_word() % 7));
		end_test("fixed address read stream");

		// heavy stalls while commands go in back to back
		ready_pct = 40;
		for (int i = 0; i < 40; i++) begin
			pick = int'(rand_word() % 6);
			a = rand_word() & 32'h3ff;
			n = 16'(1 + rand_word() % 5);
			case (pick)
				0: do_ping();
				1: do_write(a, rand_word());
				2: do_read(a);
				3: do_rstream(RSTREAM_C, a, n);
				4: do_rstream(RSTREAM, a, n);
				default: do_wstream(a, n);
			endcase
		end
		end_test("back-pressure burst");
		ready_pct = 75;

		send_beat(32'd4, 32'h10, 32'd0);
		send_beat(32'hdead_0007, 32'h20, 32'd1);
		do_ping();
		end_test("unknown opcode dropped");

		u_rsp_checker.check_total(exp_total);
		$display("totals: %0d tests, %0d responses, %0d errors", test_num - 1,
			u_rsp_checker.rsp_cnt, count_errors());
		if (count_errors() == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tb_host_bridge_asserts.sv
// concurrent checks on the Wishbone cycle rules and response hold under back-pressure
module tb_host_bridge_asserts
	import host_cmd_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic rsp_valid_i,
	input logic rsp_ready_i,
	input rsp_t rsp_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int err_cnt = 0;

	// strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_i |-> cyc_i)
		else begin
			err_cnt++;
			$error("stb high without cyc");
		end

	cyc_until_ack: assert property (@(posedge clk) disable iff (rst) cyc_i && !ack_i |=> cyc_i)
		else begin
			err_cnt++;
			$error("cyc dropped before ack");
		end

	// stalled head of the response queue must not move
	rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
		else begin
			err_cnt++;
			$error("response changed while stalled");
		end

	ack_in_stb: assert property (@(posedge clk) disable iff (rst) ack_i |-> stb_i)
		else begin
			err_cnt++;
			$error("ack without stb");
		end

endmodule

bind host_bridge_top tb_host_bridge_asserts u_asserts (
	.clk(clk), .rst(rst), .cyc_i(wb_cyc), .stb_i(wb_stb), .ack_i(wb_ack),
	.rsp_valid_i(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_i(rsp_o)
);

//--- tb_rsp_checker.sv
// response monitor comparing every host response handshake with the expected record queue
module tb_rsp_checker
	import host_cmd_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cmd_ready_i,
	input logic rsp_valid_i,
	input logic rsp_ready_i,
	input rsp_t rsp_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// expected records in command order
	rsp_t exp_q [$];
	int err_cnt;
	int rsp_cnt;
	logic rst_q;

	initial begin
		err_cnt = 0;
		rsp_cnt = 0;
		rst_q = 1'b1;
	end

	function automatic void expect_rsp(input rsp_t r);
		exp_q.push_back(r);
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic void check_total(input int expected);
		if (rsp_cnt != expected) begin
			$display("[ERROR] %0t: %0d responses seen, model expected %0d",
				$time, rsp_cnt, expected);
			err_cnt++;
		end
	endfunction

	always @(posedge clk) begin
		rsp_t want;
		// first clock out of reset
		if (rst_q && !rst && (!cmd_ready_i || rsp_valid_i)) begin
			$display("[ERROR] %0t: host side not idle after reset, ready=%b valid=%b",
				$time, cmd_ready_i, rsp_valid_i);
			err_cnt++;
		end
		rst_q = rst;
		if (!rst && rsp_valid_i && rsp_ready_i) begin
			rsp_cnt++;
			if (exp_q.size() == 0) begin
				$display("[ERROR] %0t: unexpected response status=%h addr=%h data=%h count=%0d",
					$time, rsp_i.status, rsp_i.addr, rsp_i.data, rsp_i.count);
				err_cnt++;
			end else begin
				want = exp_q.pop_front();
				if (rsp_i !== want) begin
					$display("[ERROR] %0t: got %h/%h/%h/%0d, expected %h/%h/%h/%0d",
						$time, rsp_i.status, rsp_i.addr, rsp_i.data, rsp_i.count,
						want.status, want.addr, want.data, want.count);
					err_cnt++;
				end
			end
		end
	end

endmodule

//--- wb_bus_pkg.sv
// Wishbone bus widths and the request and response records between controller and port
package wb_bus_pkg;

	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;

	// one bus transfer as issued by the controller
	typedef struct packed {
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat;
		logic                 we;
	} wb_req_t;

	// completion of a transfer, read data valid with ack
	typedef struct packed {
		logic [WB_DATA_W-1:0] dat;
		logic                 ack;
	} wb_rsp_t;

endpackage

//--- wb_master_ctrl.sv
// command decode and sequencing FSM for single and burst Wishbone transfers
module wb_master_ctrl
	import host_cmd_pkg::*;
	import wb_bus_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    cmd_empty_i,
	input  cmd_t    cmd_i,
	output logic    cmd_pop_o,
	input  logic    rsp_full_i,
	output logic    rsp_push_o,
	output rsp_t    rsp_o,
	output logic    req_valid_o,
	output wb_req_t req_o,
	input  logic    busy_i,
	input  logic    done_i,
	input  wb_rsp_t wb_rsp_i
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_DECODE,
		S_ISSUE,
		S_WAIT,
		S_WBEAT,
		S_RESP
	} state_e;

	state_e state_q;
	cmd_t cmd_q;
	logic [WB_ADDR_W-1:0] addr_q;
	logic [WB_ADDR_W-1:0] base_q;
	logic [WB_DATA_W-1:0] wdata_q;
	logic [15:0] remain_q;
	logic [15:0] total_q;
	logic we_q;
	logic incr_q;
	logic more_q;
	rsp_t rsp_q;
	logic [31:0] status;
	logic xfer_done;

	assign status    = ~cmd_q.code;
	assign xfer_done = done_i && wb_rsp_i.ack;

	// pop the opcode beat when idle, or a data beat inside a write stream
	assign cmd_pop_o   = ((state_q == S_IDLE) || (state_q == S_WBEAT)) && !cmd_empty_i;
	assign rsp_push_o  = (state_q == S_RESP) && !rsp_full_i;
	assign rsp_o       = rsp_q;
	// hold off the bus while the response queue is full, so read data always has a slot
	assign req_valid_o = (state_q == S_ISSUE) && !busy_i && !rsp_full_i;
	assign req_o       = '{adr: addr_q, dat: wdata_q, we: we_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= S_IDLE;
			remain_q <= '0;
			total_q  <= '0;
			we_q     <= 1'b0;
			incr_q   <= 1'b0;
			more_q   <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (!cmd_empty_i) begin
						cmd_q   <= cmd_i;
						state_q <= S_DECODE;
					end
				end
				S_DECODE: begin
					addr_q   <= cmd_q.addr;
					base_q   <= cmd_q.addr;
					wdata_q  <= cmd_q.data;
					remain_q <= cmd_q.data[15:0];
					total_q  <= cmd_q.data[15:0];
					// fixed-address read stream is the only non-incrementing mode
					incr_q   <= (cmd_q.code != RSTREAM);
					more_q   <= 1'b0;
					case (cmd_q.code)
						PING: begin
							rsp_q   <= '{status: status, addr: '0,
								data: PING_SIGNATURE, count: '0};
							state_q <= S_RESP;
						end
						WRITE: begin
							we_q    <= 1'b1;
							state_q <= S_ISSUE;
						end
						READ: begin
							we_q    <= 1'b0;
							state_q <= S_ISSUE;
						end
						RSTREAM_C, RSTREAM: begin
							// header first, then one record per word
							we_q    <= 1'b0;
							rsp_q   <= '{status: status, addr: cmd_q.addr,
								data: '0, count: cmd_q.data[15:0]};
							more_q  <= (cmd_q.data[15:0] != '0);
							state_q <= S_RESP;
						end
						WSTREAM_C: begin
							we_q <= 1'b1;
							if (cmd_q.data[15:0] == '0) begin
								rsp_q   <= '{status: status, addr: cmd_q.addr,
									data: '0, count: '0};
								state_q <= S_RESP;
							end else begin
								state_q <= S_WBEAT;
							end
						end
						// unknown opcode is dropped silently
						default: state_q <= S_IDLE;
					endcase
				end
				S_ISSUE: begin
					if (req_valid_o)
						state_q <= S_WAIT;
				end
				S_WAIT: begin
					if (xfer_done) begin
						case (cmd_q.code)
							WRITE: begin
								rsp_q   <= '{status: status, addr: addr_q,
									data: wdata_q, count: '0};
								state_q <= S_RESP;
							end
							READ: begin
								rsp_q   <= '{status: status, addr: addr_q,
									data: wb_rsp_i.dat, count: '0};
								state_q <= S_RESP;
							end
							RSTREAM_C, RSTREAM: begin
								// count is words left including this one
								rsp_q    <= '{status: status, addr: addr_q,
									data: wb_rsp_i.dat, count: remain_q};
								addr_q   <= incr_q ? addr_q + 1'b1 : addr_q;
								remain_q <= remain_q - 1'b1;
								more_q   <= (remain_q != 16'd1);
								state_q  <= S_RESP;
							end
							default: begin
								// write stream beat finished
								addr_q   <= incr_q ? addr_q + 1'b1 : addr_q;
								remain_q <= remain_q - 1'b1;
								if (remain_q == 16'd1) begin
									rsp_q   <= '{status: status, addr: base_q,
										data: wdata_q, count: total_q};
									state_q <= S_RESP;
								end else begin
									state_q <= S_WBEAT;
								end
							end
						endcase
					end
				end
				S_WBEAT: begin
					if (!cmd_empty_i) begin
						wdata_q <= cmd_i.data;
						state_q <= S_ISSUE;
					end
				end
				S_RESP: begin
					if (!rsp_full_i)
						state_q <= more_q ? S_ISSUE : S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

//--- wb_port.sv
// Wishbone classic cycle driver holding one request until ack and capturing read data
module wb_port
	import wb_bus_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req_valid_i,
	input  wb_req_t              req_i,
	output logic                 busy_o,
	output logic                 done_o,
	output wb_rsp_t              rsp_o,
	output logic [WB_ADDR_W-1:0] wb_adr_o,
	output logic [WB_DATA_W-1:0] wb_dat_o,
	input  logic [WB_DATA_W-1:0] wb_dat_i,
	output logic                 wb_we_o,
	output logic                 wb_cyc_o,
	output logic                 wb_stb_o,
	input  logic                 wb_ack_i
);
	logic cyc_q;
	logic done_q;
	wb_req_t req_q;
	logic [WB_DATA_W-1:0] rdata_q;
	logic start;
	logic finish;

	assign start  = req_valid_i && !cyc_q;
	assign finish = cyc_q && wb_ack_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= finish;
			// cyc and stb fall in the cycle after ack
			if (start)
				cyc_q <= 1'b1;
			else if (finish)
				cyc_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			req_q <= req_i;
		if (finish)
			rdata_q <= wb_dat_i;
	end

	assign busy_o   = cyc_q;
	assign done_o   = done_q;
	assign rsp_o    = '{dat: rdata_q, ack: done_q};
	assign wb_adr_o = req_q.adr;
	assign wb_dat_o = req_q.dat;
	assign wb_we_o  = req_q.we;
	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = cyc_q;

endmodule

//--- wb_ram.sv
// Wishbone slave word memory with a programmable number of wait states
module wb_ram
	import wb_bus_pkg::*;
#(
	parameter int RAM_ADDR_W  = 8,
	parameter int WAIT_STATES = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [WB_ADDR_W-1:0] wb_adr_i,
	input  logic [WB_DATA_W-1:0] wb_dat_i,
	output logic [WB_DATA_W-1:0] wb_dat_o,
	input  logic                 wb_we_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	output logic                 wb_ack_o
);
	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [WB_DATA_W-1:0] mem [2**RAM_ADDR_W];
	logic [WB_DATA_W-1:0] rdata_q;
	logic [CNT_W-1:0] wait_q;
	logic ack_q;
	logic [RAM_ADDR_W-1:0] idx;
	logic pending;
	logic fire;

	// upper address bits ignored, so accesses wrap
	assign idx     = wb_adr_i[RAM_ADDR_W-1:0];
	assign pending = wb_cyc_i && wb_stb_i && !ack_q;
	assign fire    = pending && (wait_q == CNT_W'(WAIT_STATES));

	initial begin
		for (int i = 0; i < 2**RAM_ADDR_W; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wait_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			// single-cycle ack after the wait states have run out
			ack_q <= fire;
			if (pending && !fire)
				wait_q <= wait_q + 1'b1;
			else
				wait_q <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire)
			rdata_q <= mem[idx];
		if (ack_q && wb_we_i)
			mem[idx] <= wb_dat_i;
	end

	assign wb_dat_o = rdata_q;
	assign wb_ack_o = ack_q;

endmodule
